// ==== verilog/cache_cfg_pkg.sv ====
`default_nettype none

package cache_cfg_pkg;

    // DRAM line address width
    localparam int DRAM_ADDR_WIDTH = 26;

    // Bits needed to index a bank, never less than one
    function automatic int BANK_SEL_WIDTH(input int num_banks);
        int width;
        width = 1;
        if (num_banks > 1) begin
            width = $clog2(num_banks);
        end
        return width;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/dram_req_pkg.sv ====
`default_nettype none

package dram_req_pkg;

    // Direction of a DRAM request, as driven on the rw line
    typedef enum logic {
        DRAM_RD = 1'b0,
        DRAM_WR = 1'b1
    } dram_op_e;

endpackage

`default_nettype wire

// ==== verilog/wb_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface wb_req_if import cache_cfg_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int LINE_BYTES = 16
) ();

    logic                                    valid;
    logic [BANK_SEL_WIDTH(NUM_BANKS)-1:0]    bank;
    logic [LINE_BYTES-1:0]                   byteen;
    logic [DRAM_ADDR_WIDTH-1:0]              addr;
    logic [8*LINE_BYTES-1:0]                 data;
    logic                                    ready;

    modport src (output valid, bank, byteen, addr, data, input ready);
    modport dst (input valid, bank, byteen, addr, data, output ready);

endinterface

`default_nettype wire

// ==== verilog/wb_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_select import cache_cfg_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int LINE_BYTES = 16
) (
    input  wire [NUM_BANKS-1:0]                        wb_valid,
    input  wire [NUM_BANKS-1:0][LINE_BYTES-1:0]        wb_byteen,
    input  wire [NUM_BANKS-1:0][DRAM_ADDR_WIDTH-1:0]   wb_addr,
    input  wire [NUM_BANKS-1:0][8*LINE_BYTES-1:0]      wb_data,
    output logic [NUM_BANKS-1:0]                       wb_ready,

    wb_req_if.src                                      wb
);

    localparam int BANK_BITS = BANK_SEL_WIDTH(NUM_BANKS);

    logic [BANK_BITS-1:0] sel_bank;
    logic                 sel_valid;

    // Lowest valid bank wins
    always_comb begin
        sel_bank  = '0;
        sel_valid = 1'b0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (wb_valid[i]) begin
                sel_bank  = BANK_BITS'(i);
                sel_valid = 1'b1;
            end
        end
    end

    assign wb.valid  = sel_valid;
    assign wb.bank   = sel_bank;
    assign wb.byteen = wb_byteen[sel_bank];
    assign wb.addr   = wb_addr[sel_bank];
    assign wb.data   = wb_data[sel_bank];

    // Only the granted bank sees the DRAM ready
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            wb_ready[i] = wb.ready && wb.valid && (wb.bank == BANK_BITS'(i));
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dram_fill_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_fill_queue import cache_cfg_pkg::*; #(
    parameter int NUM_BANKS = 4,
    parameter int DFQQ_SIZE = 4
) (
    input  wire                                        clk,
    input  wire                                        rst,

    input  wire [NUM_BANKS-1:0]                        fill_valid,
    input  wire [NUM_BANKS-1:0][DRAM_ADDR_WIDTH-1:0]   fill_addr,
    output logic                                       fill_ready,

    output logic                                       head_valid,
    output logic [DRAM_ADDR_WIDTH-1:0]                 head_addr,
    input  wire                                        pop
);

    localparam int BANK_BITS = BANK_SEL_WIDTH(NUM_BANKS);
    localparam int PTR_W     = (DFQQ_SIZE > 1) ? $clog2(DFQQ_SIZE) : 1;
    localparam int CNT_W     = $clog2(DFQQ_SIZE + 1);

    // One entry per accepted group
    logic [NUM_BANKS-1:0]                        mask_q [DFQQ_SIZE];
    logic [NUM_BANKS-1:0][DRAM_ADDR_WIDTH-1:0]   addr_q [DFQQ_SIZE];

    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     count;

    logic [NUM_BANKS-1:0] head_mask;
    logic [NUM_BANKS-1:0] head_rest;
    logic [BANK_BITS-1:0] head_bank;
    logic                 push;
    logic                 pop_bank;
    logic                 pop_entry;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DFQQ_SIZE - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign fill_ready = (count != CNT_W'(DFQQ_SIZE));
    assign head_valid = (count != '0);
    assign push       = (|fill_valid) && fill_ready;

    assign head_mask  = mask_q[rd_ptr];

    // Serve the head group from its lowest pending bank upward
    always_comb begin
        head_bank = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (head_mask[i]) begin
                head_bank = BANK_BITS'(i);
            end
        end
        head_rest            = head_mask;
        head_rest[head_bank] = 1'b0;
    end

    assign head_addr = addr_q[rd_ptr][head_bank];
    assign pop_bank  = pop && head_valid;
    assign pop_entry = pop_bank && (head_rest == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_entry) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop_entry) begin
                count <= count + 1'b1;
            end else if (!push && pop_entry) begin
                count <= count - 1'b1;
            end
        end
    end

    // Push and pop never touch the same slot
    always_ff @(posedge clk) begin
        if (push) begin
            mask_q[wr_ptr] <= fill_valid;
            addr_q[wr_ptr] <= fill_addr;
        end
        if (pop_bank) begin
            mask_q[rd_ptr] <= head_rest;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dram_prefetcher.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_prefetcher import cache_cfg_pkg::*; #(
    parameter int PRFQ_SIZE   = 4,
    parameter int PRFQ_STRIDE = 1
) (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          issue_fill,
    input  wire [DRAM_ADDR_WIDTH-1:0]    issue_addr,

    output logic                         pref_valid,
    output logic [DRAM_ADDR_WIDTH-1:0]   pref_addr,
    input  wire                          pref_pop
);

    localparam int PTR_W = (PRFQ_SIZE > 1) ? $clog2(PRFQ_SIZE) : 1;
    localparam int CNT_W = $clog2(PRFQ_SIZE + 1);

    logic [DRAM_ADDR_WIDTH-1:0] addr_q [PRFQ_SIZE];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(PRFQ_SIZE - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    // Enqueue is silently lost when full
    assign push       = issue_fill && (count != CNT_W'(PRFQ_SIZE));
    assign pop        = pref_pop && pref_valid;
    assign pref_valid = (count != '0);
    assign pref_addr  = addr_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Next line address wraps at the address width
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= issue_addr + DRAM_ADDR_WIDTH'(PRFQ_STRIDE);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dram_req_arb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_req_arb import cache_cfg_pkg::*, dram_req_pkg::*; #(
    parameter int NUM_BANKS   = 4,
    parameter int LINE_BYTES  = 16,
    parameter int DFQQ_SIZE   = 4,
    parameter int PRFQ_SIZE   = 4,
    parameter int PRFQ_STRIDE = 1
) (
    input  wire                                        clk,
    input  wire                                        rst,

    // Fill requests
    input  wire [NUM_BANKS-1:0]                        fill_valid,
    input  wire [NUM_BANKS-1:0][DRAM_ADDR_WIDTH-1:0]   fill_addr,
    output logic                                       fill_ready,

    // Writeback requests
    input  wire [NUM_BANKS-1:0]                        wb_valid,
    input  wire [NUM_BANKS-1:0][LINE_BYTES-1:0]        wb_byteen,
    input  wire [NUM_BANKS-1:0][DRAM_ADDR_WIDTH-1:0]   wb_addr,
    input  wire [NUM_BANKS-1:0][8*LINE_BYTES-1:0]      wb_data,
    output logic [NUM_BANKS-1:0]                       wb_ready,

    // DRAM request channel
    output logic                                       dram_req_valid,
    output dram_op_e                                   dram_req_rw,
    output logic [LINE_BYTES-1:0]                      dram_req_byteen,
    output logic [DRAM_ADDR_WIDTH-1:0]                 dram_req_addr,
    output logic [8*LINE_BYTES-1:0]                    dram_req_data,
    input  wire                                        dram_req_ready
);

    logic                       head_valid;
    logic [DRAM_ADDR_WIDTH-1:0] head_addr;
    logic                       fill_pop;
    logic                       pref_valid;
    logic [DRAM_ADDR_WIDTH-1:0] pref_addr;
    logic                       pref_pop;

    wb_req_if #(
        .NUM_BANKS  (NUM_BANKS),
        .LINE_BYTES (LINE_BYTES)
    ) wb_req ();

    wb_select #(
        .NUM_BANKS  (NUM_BANKS),
        .LINE_BYTES (LINE_BYTES)
    ) wb_sel (
        .wb_valid   (wb_valid),
        .wb_byteen  (wb_byteen),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .wb_ready   (wb_ready),
        .wb         (wb_req.src)
    );

    dram_fill_queue #(
        .NUM_BANKS  (NUM_BANKS),
        .DFQQ_SIZE  (DFQQ_SIZE)
    ) fill_q (
        .clk        (clk),
        .rst        (rst),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_ready (fill_ready),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .pop        (fill_pop)
    );

    // Only fill reads spawn prefetches
    dram_prefetcher #(
        .PRFQ_SIZE   (PRFQ_SIZE),
        .PRFQ_STRIDE (PRFQ_STRIDE)
    ) prefetch (
        .clk         (clk),
        .rst         (rst),
        .issue_fill  (fill_pop),
        .issue_addr  (head_addr),
        .pref_valid  (pref_valid),
        .pref_addr   (pref_addr),
        .pref_pop    (pref_pop)
    );

    assign wb_req.ready = dram_req_ready;

    // Writeback over fill over prefetch
    assign fill_pop = dram_req_ready && !wb_req.valid && head_valid;
    assign pref_pop = dram_req_ready && !wb_req.valid && !head_valid && pref_valid;

    assign dram_req_valid  = wb_req.valid || head_valid || pref_valid;
    assign dram_req_rw     = wb_req.valid ? DRAM_WR : DRAM_RD;
    assign dram_req_byteen = wb_req.valid ? wb_req.byteen : '1;
    assign dram_req_addr   = wb_req.valid ? wb_req.addr : (head_valid ? head_addr : pref_addr);
    assign dram_req_data   = wb_req.valid ? wb_req.data : '0;

endmodule

`default_nettype wire

// ==== test/dram_req_arb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_req_arb_tb import cache_cfg_pkg::*, dram_req_pkg::*; ();

    localparam int NUM_BANKS   = 4;
    localparam int LINE_BYTES  = 16;
    localparam int DFQQ_SIZE   = 4;
    localparam int PRFQ_SIZE   = 4;
    localparam int PRFQ_STRIDE = 1;
    localparam int AW          = DRAM_ADDR_WIDTH;
    localparam int NUM_SC      = 5;
    localparam int MAX_EXP     = 2 * DFQQ_SIZE + PRFQ_SIZE;
    // Reset counts as one extra scenario
    localparam int MAX_CYCLES  = 40 * (NUM_SC + 1);

    logic                                   clk;
    logic                                   rst;
    logic [NUM_BANKS-1:0]                   fill_valid;
    logic [NUM_BANKS-1:0][AW-1:0]           fill_addr;
    logic                                   fill_ready;
    logic [NUM_BANKS-1:0]                   wb_valid;
    logic [NUM_BANKS-1:0][LINE_BYTES-1:0]   wb_byteen;
    logic [NUM_BANKS-1:0][AW-1:0]           wb_addr;
    logic [NUM_BANKS-1:0][8*LINE_BYTES-1:0] wb_data;
    logic [NUM_BANKS-1:0]                   wb_ready;
    logic                                   dram_req_valid;
    dram_op_e                               dram_req_rw;
    logic [LINE_BYTES-1:0]                  dram_req_byteen;
    logic [AW-1:0]                          dram_req_addr;
    logic [8*LINE_BYTES-1:0]                dram_req_data;
    logic                                   dram_req_ready;

    // Scenario table, stimulus then expected DRAM transfers in order
    string                                  sc_name      [NUM_SC];
    logic [NUM_BANKS-1:0]                   sc_fill_mask [NUM_SC];
    logic [NUM_BANKS-1:0][AW-1:0]           sc_fill_addr [NUM_SC];
    int                                     sc_groups    [NUM_SC];
    int                                     sc_accept    [NUM_SC];
    logic [NUM_BANKS-1:0]                   sc_wb_mask   [NUM_SC];
    logic [NUM_BANKS-1:0][AW-1:0]           sc_wb_addr   [NUM_SC];
    logic [NUM_BANKS-1:0][LINE_BYTES-1:0]   sc_wb_byteen [NUM_SC];
    logic [NUM_BANKS-1:0][8*LINE_BYTES-1:0] sc_wb_data   [NUM_SC];
    int                                     sc_hold      [NUM_SC];
    bit                                     sc_idle_end  [NUM_SC];
    int                                     sc_n_exp     [NUM_SC];
    dram_op_e                               ex_rw        [NUM_SC][MAX_EXP];
    logic [AW-1:0]                          ex_addr      [NUM_SC][MAX_EXP];
    int                                     ex_bank      [NUM_SC][MAX_EXP];

    int seed;
    int cycles = 0;

    dram_req_arb #(
        .NUM_BANKS   (NUM_BANKS),
        .LINE_BYTES  (LINE_BYTES),
        .DFQQ_SIZE   (DFQQ_SIZE),
        .PRFQ_SIZE   (PRFQ_SIZE),
        .PRFQ_STRIDE (PRFQ_STRIDE)
    ) dut0 (
        .clk             (clk),
        .rst             (rst),
        .fill_valid      (fill_valid),
        .fill_addr       (fill_addr),
        .fill_ready      (fill_ready),
        .wb_valid        (wb_valid),
        .wb_byteen       (wb_byteen),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .wb_ready        (wb_ready),
        .dram_req_valid  (dram_req_valid),
        .dram_req_rw     (dram_req_rw),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_addr   (dram_req_addr),
        .dram_req_data   (dram_req_data),
        .dram_req_ready  (dram_req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles > MAX_CYCLES);
        $display("tests failed");
        $fatal(1, "Timeout: the scenarios did not finish within %0d cycles", MAX_CYCLES);
    end

    task automatic check(input string name, input string what,
                         input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %0h, actual %0h", name, what, expected, actual);
            $display("tests failed");
            $fatal(1, "Check failed in %s", name);
        end
    endtask

    task automatic define_scenario(input int s, input string name,
                                   input logic [NUM_BANKS-1:0] fill_mask,
                                   input int groups, input int accept,
                                   input logic [NUM_BANKS-1:0] wb_mask,
                                   input int hold, input bit idle_end);
        sc_name[s]      = name;
        sc_fill_mask[s] = fill_mask;
        sc_fill_addr[s] = '0;
        sc_groups[s]    = groups;
        sc_accept[s]    = accept;
        sc_wb_mask[s]   = wb_mask;
        sc_wb_addr[s]   = '0;
        sc_hold[s]      = hold;
        sc_idle_end[s]  = idle_end;
        sc_n_exp[s]     = 0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            sc_wb_byteen[s][i] = LINE_BYTES'($random(seed));
            sc_wb_data[s][i]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    endtask

    task automatic expect_xfer(input int s, input dram_op_e rw, input logic [AW-1:0] addr,
                               input int bank);
        ex_rw[s][sc_n_exp[s]]   = rw;
        ex_addr[s][sc_n_exp[s]] = addr;
        ex_bank[s][sc_n_exp[s]] = bank;
        sc_n_exp[s]++;
    endtask

    task automatic build_table();
        define_scenario(0, "fill_order", 4'b0101, 1, 1, 4'b0000, 0, 1'b1);
        sc_fill_addr[0][0] = AW'('h100);
        sc_fill_addr[0][2] = AW'('h300);
        expect_xfer(0, DRAM_RD, AW'('h100), 0);
        expect_xfer(0, DRAM_RD, AW'('h300), 0);
        expect_xfer(0, DRAM_RD, AW'('h100 + PRFQ_STRIDE), 0);
        expect_xfer(0, DRAM_RD, AW'('h300 + PRFQ_STRIDE), 0);

        define_scenario(1, "wb_then_fill", 4'b0010, 1, 1, 4'b1010, 0, 1'b1);
        sc_fill_addr[1][1] = AW'('h2000);
        sc_wb_addr[1][1]   = AW'('h3010);
        sc_wb_addr[1][3]   = AW'('h3030);
        expect_xfer(1, DRAM_WR, AW'('h3010), 1);
        expect_xfer(1, DRAM_WR, AW'('h3030), 3);
        expect_xfer(1, DRAM_RD, AW'('h2000), 0);
        expect_xfer(1, DRAM_RD, AW'('h2000 + PRFQ_STRIDE), 0);

        // Ends with one prefetch still queued for the next scenario
        define_scenario(2, "pref_pending", 4'b0011, 1, 1, 4'b0000, 0, 1'b0);
        sc_fill_addr[2][0] = AW'('h40);
        sc_fill_addr[2][1] = AW'('h50);
        expect_xfer(2, DRAM_RD, AW'('h40), 0);
        expect_xfer(2, DRAM_RD, AW'('h50), 0);
        expect_xfer(2, DRAM_RD, AW'('h40 + PRFQ_STRIDE), 0);

        define_scenario(3, "fill_over_pref", 4'b0001, 1, 1, 4'b0000, 2, 1'b1);
        sc_fill_addr[3][0] = AW'('h70);
        expect_xfer(3, DRAM_RD, AW'('h70), 0);
        expect_xfer(3, DRAM_RD, AW'('h50 + PRFQ_STRIDE), 0);
        expect_xfer(3, DRAM_RD, AW'('h70 + PRFQ_STRIDE), 0);

        define_scenario(4, "queue_full", 4'b1001, DFQQ_SIZE + 1, DFQQ_SIZE, 4'b0000,
                        2 * DFQQ_SIZE, 1'b1);
        sc_fill_addr[4][0] = AW'('h1000);
        sc_fill_addr[4][3] = AW'('h1300);
        for (int g = 0; g < DFQQ_SIZE; g++) begin
            expect_xfer(4, DRAM_RD, AW'('h1000 + g * 'h10), 0);
            expect_xfer(4, DRAM_RD, AW'('h1300 + g * 'h10), 0);
        end
        // Only the first PRFQ_SIZE issued reads find room in the prefetch queue
        for (int p = 0; p < PRFQ_SIZE; p++) begin
            expect_xfer(4, DRAM_RD, ex_addr[4][p] + AW'(PRFQ_STRIDE), 0);
        end
    endtask

    task automatic run_scenario(input int s);
        int                   k;
        int                   g;
        int                   accepted;
        int                   hold;
        bit                   done;
        logic [NUM_BANKS-1:0] wb_pend;
        logic [NUM_BANKS-1:0] exp_ready;
        k        = 0;
        g        = 0;
        accepted = 0;
        hold     = sc_hold[s];
        done     = 1'b0;
        wb_pend  = sc_wb_mask[s];
        while (!done) begin
            @(negedge clk);
            dram_req_ready = (hold == 0);
            if (hold > 0) begin
                hold--;
            end
            wb_valid   = wb_pend;
            wb_byteen  = sc_wb_byteen[s];
            wb_addr    = sc_wb_addr[s];
            wb_data    = sc_wb_data[s];
            fill_valid = (g < sc_groups[s]) ? sc_fill_mask[s] : '0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                fill_addr[i] = sc_fill_addr[s][i] + AW'(g * 'h10);
            end
            @(posedge clk);
            exp_ready = '0;
            if (dram_req_ready && k < sc_n_exp[s] && ex_rw[s][k] == DRAM_WR) begin
                exp_ready[ex_bank[s][k]] = 1'b1;
            end
            check(sc_name[s], "wb_ready", exp_ready, wb_ready);
            if (dram_req_valid && dram_req_ready) begin
                if (k >= sc_n_exp[s]) begin
                    check(sc_name[s], "transfer count", sc_n_exp[s], k + 1);
                end
                check(sc_name[s], "rw", ex_rw[s][k], dram_req_rw);
                check(sc_name[s], "addr", ex_addr[s][k], dram_req_addr);
                check(sc_name[s], "byteen",
                      (ex_rw[s][k] == DRAM_WR) ? sc_wb_byteen[s][ex_bank[s][k]]
                                               : {LINE_BYTES{1'b1}},
                      dram_req_byteen);
                check(sc_name[s], "data",
                      (ex_rw[s][k] == DRAM_WR) ? sc_wb_data[s][ex_bank[s][k]] : '0,
                      dram_req_data);
                k++;
            end
            // A refused group withdraws the rest of the offer
            if (|fill_valid) begin
                if (fill_ready) begin
                    accepted++;
                    g++;
                end else begin
                    g = sc_groups[s];
                end
            end
            wb_pend = wb_pend & ~wb_ready;
            done = (k == sc_n_exp[s]) && (g >= sc_groups[s]) && (wb_pend == '0);
        end
        check(sc_name[s], "accepted groups", sc_accept[s], accepted);
        if (sc_idle_end[s]) begin
            @(negedge clk);
            fill_valid = '0;
            wb_valid   = '0;
            @(posedge clk);
            check(sc_name[s], "dram_req_valid after drain", 0, dram_req_valid);
        end
    endtask

    initial begin
        seed           = 49;
        rst            = 1'b1;
        fill_valid     = '0;
        fill_addr      = '0;
        wb_valid       = '0;
        wb_byteen      = '0;
        wb_addr        = '0;
        wb_data        = '0;
        dram_req_ready = 1'b0;
        build_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check("reset", "dram_req_valid", 0, dram_req_valid);
        check("reset", "fill_ready", 1, fill_ready);
        check("reset", "wb_ready", 0, wb_ready);
        for (int s = 0; s < NUM_SC; s++) begin
            run_scenario(s);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/cache_cfg_pkg.sv
verilog/dram_req_pkg.sv
verilog/wb_req_if.sv
verilog/wb_select.sv
verilog/dram_fill_queue.sv
verilog/dram_prefetcher.sv
verilog/dram_req_arb.sv
test/dram_req_arb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status reports pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module dram_req_arb_tb \
        -f build.f -o dram_req_arb_sim \
    && ./obj_dir/dram_req_arb_sim \
    || { echo "simulation did not pass"; exit 1; }
